//--- thr_params.svh
/*
 * thread count and thread id width for the thread-switch unit
 * THR_NUM must be a power of two from 2 to 8
 * THR_ID_W follows from THR_NUM and is not set by hand
 */
`ifndef THR_PARAMS_SVH
`define THR_PARAMS_SVH

// hardware threads in the fetch stage
`define THR_NUM 4

// bits in a thread id
`define THR_ID_W ($clog2(`THR_NUM))

`endif

//--- thr_pkg.sv
/*
 * shared types for the thread-switch unit
 * state encodings match the original thread FSM
 * command literals carry a CMD_ prefix since HALT is already a state name
 */
`include "thr_params.svh"

package thr_pkg;

   // thread FSM state, 5-bit one-off encodings
   typedef enum logic [4:0]
   {
      IDLE     = 5'b00000,
      HALT     = 5'b00010,
      RDY      = 5'b11001,
      RUN      = 5'b00101,
      WAIT     = 5'b00001,
      SPEC_RDY = 5'b10011,
      SPEC_RUN = 5'b00111
   } thr_state_e;

   // per-thread event strobes, all single cycle
   typedef struct packed
   {
      logic completion;   // awaited op finished
      logic schedule;     // picked to run
      logic spec_ld;      // speculative switch in
      logic ldhit;        // speculation was right
      logic stall;        // ldmiss, imiss or trap
      logic int_activate;
      logic halt_thread;
      logic start_thread;
      logic nuke_thread;
      logic thaw_thread;
      logic rst_thread;
   } thr_evt_t;

   // levels shared by all threads
   typedef struct packed
   {
      logic switch_out; // running thread switched out
      logic sw_cond;    // wait for completion
   } thr_common_t;

   // control command code on the cmd port
   typedef enum logic [2:0]
   {
      CMD_NONE     = 3'd0,
      CMD_START    = 3'd1,
      CMD_HALT     = 3'd2,
      CMD_NUKE     = 3'd3,
      CMD_THAW     = 3'd4,
      CMD_RST      = 3'd5,
      CMD_ACTIVATE = 3'd6
   } thr_cmd_e;

   // debug state overwrite
   typedef struct packed
   {
      logic                 wr_en;
      logic [`THR_ID_W-1:0] tid;
      thr_state_e           state;
   } thr_dbg_t;

endpackage

//--- thr_evt_decode.sv
/*
 * event front end for the thread-switch unit
 * every input is flopped once, then ids expand into one-hot strobes
 * the schedule field is always 0 here, the picker adds it later
 * events never queue; each registered strobe lives one cycle
 */
`include "thr_params.svh"

module thr_evt_decode
(
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 comp_valid,
   input  logic                                 stall_valid,
   input  logic                                 spec_valid,
   input  logic                                 ldhit_valid,
   input  logic [`THR_ID_W-1:0]                 comp_tid,
   input  logic [`THR_ID_W-1:0]                 stall_tid,
   input  logic [`THR_ID_W-1:0]                 spec_tid,
   input  logic [`THR_ID_W-1:0]                 ldhit_tid,
   input  logic [`THR_ID_W-1:0]                 cmd_tid,
   input  thr_pkg::thr_cmd_e                    cmd,
   input  thr_pkg::thr_common_t                 common,
   input  thr_pkg::thr_dbg_t                    dbg,
   output thr_pkg::thr_evt_t [`THR_NUM-1:0]     evt,
   output thr_pkg::thr_common_t                 com_q,
   output thr_pkg::thr_dbg_t                    dbg_q
);

   logic                 comp_v_q, stall_v_q, spec_v_q, ldhit_v_q;
   logic [`THR_ID_W-1:0] comp_tid_q, stall_tid_q, spec_tid_q, ldhit_tid_q, cmd_tid_q;
   thr_pkg::thr_cmd_e    cmd_q;
   logic                 dbg_wr_q;
   logic [`THR_ID_W-1:0] dbg_tid_q;
   thr_pkg::thr_state_e  dbg_state_q;
   logic                 cmd_hit; // command aimed at the thread in the loop

   // control side, cleared on reset
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         comp_v_q  <= 1'b0;
         stall_v_q <= 1'b0;
         spec_v_q  <= 1'b0;
         ldhit_v_q <= 1'b0;
         cmd_q     <= thr_pkg::CMD_NONE;
         com_q     <= '0;
         dbg_wr_q  <= 1'b0;
      end
      else
      begin
         comp_v_q  <= comp_valid;
         stall_v_q <= stall_valid;
         spec_v_q  <= spec_valid;
         ldhit_v_q <= ldhit_valid;
         cmd_q     <= cmd;
         com_q     <= common;
         dbg_wr_q  <= dbg.wr_en;
      end
   end

   // ids and debug data, only looked at with a valid
   always_ff @(posedge clk)
   begin
      comp_tid_q  <= comp_tid;
      stall_tid_q <= stall_tid;
      spec_tid_q  <= spec_tid;
      ldhit_tid_q <= ldhit_tid;
      cmd_tid_q   <= cmd_tid;
      dbg_tid_q   <= dbg.tid;
      dbg_state_q <= dbg.state;
   end

   assign dbg_q = '{wr_en: dbg_wr_q, tid: dbg_tid_q, state: dbg_state_q};

   // one-hot expansion per thread
   always_comb
   begin
      cmd_hit = 1'b0;
      for (int t = 0; t < `THR_NUM; t++)
      begin
         evt[t]            = '0; // schedule stays 0
         evt[t].completion = comp_v_q & (comp_tid_q == `THR_ID_W'(t));
         evt[t].stall      = stall_v_q & (stall_tid_q == `THR_ID_W'(t));
         evt[t].spec_ld    = spec_v_q & (spec_tid_q == `THR_ID_W'(t));
         evt[t].ldhit      = ldhit_v_q & (ldhit_tid_q == `THR_ID_W'(t));
         cmd_hit           = (cmd_tid_q == `THR_ID_W'(t));
         // command code maps onto exactly one field
         evt[t].start_thread = cmd_hit & (cmd_q == thr_pkg::CMD_START);
         evt[t].halt_thread  = cmd_hit & (cmd_q == thr_pkg::CMD_HALT);
         evt[t].nuke_thread  = cmd_hit & (cmd_q == thr_pkg::CMD_NUKE);
         evt[t].thaw_thread  = cmd_hit & (cmd_q == thr_pkg::CMD_THAW);
         evt[t].rst_thread   = cmd_hit & (cmd_q == thr_pkg::CMD_RST);
         evt[t].int_activate = cmd_hit & (cmd_q == thr_pkg::CMD_ACTIVATE);
      end
   end

endmodule

//--- thr_fsm.sv
/*
 * state machine of one hardware thread
 * priorities follow the original switch logic table
 * dbg_wr loads dbg_state and wins over every event of that cycle
 * an unknown encoding leaves only on rst_thread or nuke_thread
 */
module thr_fsm
(
   input  logic                 clk,
   input  logic                 reset,
   input  thr_pkg::thr_evt_t    evt,
   input  thr_pkg::thr_common_t com,
   input  logic                 dbg_wr,
   input  thr_pkg::thr_state_e  dbg_state,
   output thr_pkg::thr_state_e  state
);

   thr_pkg::thr_state_e next_state;

   always_comb
   begin
      next_state = state; // hold unless a branch below applies
      case (state)
         thr_pkg::IDLE:
         begin
            // other events ignored while dead
            if (evt.rst_thread | evt.thaw_thread)
               next_state = thr_pkg::WAIT;
            else if (evt.start_thread)
               next_state = thr_pkg::RDY;
         end
         thr_pkg::HALT:
         begin
            if (evt.nuke_thread)
               next_state = thr_pkg::IDLE;
            else if (evt.rst_thread | evt.thaw_thread)
               next_state = thr_pkg::WAIT;
            else if (evt.int_activate | evt.start_thread)
               next_state = thr_pkg::RDY;
         end
         thr_pkg::RDY:
         begin
            if (evt.stall) // trap kills the thread before it runs
               next_state = thr_pkg::WAIT;
            else if (evt.schedule)
               next_state = thr_pkg::RUN;
         end
         thr_pkg::RUN:
         begin
            if (evt.stall | com.sw_cond)
               next_state = thr_pkg::WAIT;
            else if (com.switch_out) // fetch switched it out
               next_state = thr_pkg::RDY;
         end
         thr_pkg::WAIT:
         begin
            if (evt.nuke_thread)
               next_state = thr_pkg::IDLE;
            else if (evt.halt_thread)
               next_state = thr_pkg::HALT;
            else if (evt.stall) // blocks spec_ld and completion
               next_state = thr_pkg::WAIT;
            else if (evt.spec_ld)
               next_state = thr_pkg::SPEC_RDY;
            else if (evt.completion)
               next_state = thr_pkg::RDY;
         end
         thr_pkg::SPEC_RDY:
         begin
            if (evt.stall)
               next_state = thr_pkg::WAIT;
            else if (evt.schedule & ~evt.ldhit)
               next_state = thr_pkg::SPEC_RUN;
            else if (evt.schedule & evt.ldhit) // hit known at switch in
               next_state = thr_pkg::RUN;
            else if (evt.ldhit)
               next_state = thr_pkg::RDY;
         end
         thr_pkg::SPEC_RUN:
         begin
            if (evt.stall | com.sw_cond)
               next_state = thr_pkg::WAIT;
            else if (evt.ldhit & com.switch_out)
               next_state = thr_pkg::RDY;
            else if (evt.ldhit)
               next_state = thr_pkg::RUN;
            else if (com.switch_out) // still speculative
               next_state = thr_pkg::SPEC_RDY;
         end
         default:
         begin
            if (evt.rst_thread)
               next_state = thr_pkg::WAIT;
            else if (evt.nuke_thread)
               next_state = thr_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= thr_pkg::IDLE;
      else if (dbg_wr)
         state <= dbg_state; // debug overwrite
      else
         state <= next_state;
   end

endmodule

//--- thr_pick.sv
/*
 * round-robin thread picker
 * schedules one RDY or SPEC_RDY thread only while none is running
 * the pointer names the first thread searched and moves past each grant
 * run_valid and run_tid are combinational, lowest running index wins
 */
`include "thr_params.svh"

module thr_pick
(
   input  logic                                   clk,
   input  logic                                   reset,
   input  thr_pkg::thr_state_e [`THR_NUM-1:0]     states,
   output logic [`THR_NUM-1:0]                    sched,
   output logic                                   run_valid,
   output logic [`THR_ID_W-1:0]                   run_tid
);

   logic [`THR_ID_W-1:0] ptr;       // round-robin start point
   logic [`THR_ID_W-1:0] idx;       // thread under test in the search
   logic [`THR_ID_W-1:0] grant_tid;
   logic                 grant;
   logic [`THR_NUM-1:0]  ready;
   logic [`THR_NUM-1:0]  running;

   always_comb
   begin
      for (int t = 0; t < `THR_NUM; t++)
      begin
         ready[t]   = (states[t] == thr_pkg::RDY) | (states[t] == thr_pkg::SPEC_RDY);
         running[t] = (states[t] == thr_pkg::RUN) | (states[t] == thr_pkg::SPEC_RUN);
      end
   end

   // running thread encode, downward so the lowest index is kept
   always_comb
   begin
      run_tid = '0;
      for (int t = `THR_NUM - 1; t >= 0; t--)
      begin
         if (running[t])
            run_tid = `THR_ID_W'(t);
      end
   end

   assign run_valid = |running;

   // rotating search from ptr, wraps since THR_NUM is a power of two
   always_comb
   begin
      grant     = 1'b0;
      grant_tid = '0;
      idx       = '0;
      for (int k = 0; k < `THR_NUM; k++)
      begin
         idx = ptr + `THR_ID_W'(k);
         if (!grant && ready[idx])
         begin
            grant     = 1'b1;
            grant_tid = idx;
         end
      end
      sched = '0;
      if (grant && !run_valid) // only one thread runs at a time
         sched[grant_tid] = 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         ptr <= '0;
      else if (|sched)
         ptr <= grant_tid + 1'b1; // next search starts past the grant
   end

endmodule

//--- thr_switch_top.sv
/*
 * thread-switch unit top level
 * decoder feeds THR_NUM identical thread FSMs, the picker drains them
 * state latency from an input event is 2 cycles, debug writes too
 * switch_out and sw_cond apply to all threads alike
 */
`include "thr_params.svh"

module thr_switch_top
(
   input  logic                               clk,
   input  logic                               reset,
   input  logic                               comp_valid,
   input  logic [`THR_ID_W-1:0]               comp_tid,
   input  logic                               stall_valid,
   input  logic [`THR_ID_W-1:0]               stall_tid,
   input  logic                               spec_valid,
   input  logic [`THR_ID_W-1:0]               spec_tid,
   input  logic                               ldhit_valid,
   input  logic [`THR_ID_W-1:0]               ldhit_tid,
   input  thr_pkg::thr_cmd_e                  cmd,
   input  logic [`THR_ID_W-1:0]               cmd_tid,
   input  thr_pkg::thr_common_t               common,
   input  thr_pkg::thr_dbg_t                  dbg,
   output thr_pkg::thr_state_e [`THR_NUM-1:0] thr_state,
   output logic                               run_valid,
   output logic [`THR_ID_W-1:0]               run_tid
);

   thr_pkg::thr_evt_t [`THR_NUM-1:0] evt;   // decoded, schedule still 0
   thr_pkg::thr_common_t             com_q;
   thr_pkg::thr_dbg_t                dbg_q;
   logic [`THR_NUM-1:0]              sched;

   thr_evt_decode u_decode (.clk, .reset, .comp_valid, .stall_valid, .spec_valid,
                            .ldhit_valid, .comp_tid, .stall_tid, .spec_tid, .ldhit_tid,
                            .cmd_tid, .cmd, .common, .dbg, .evt, .com_q, .dbg_q);

   for (genvar i = 0; i < `THR_NUM; i++)
   begin : g_thr
      thr_pkg::thr_evt_t evt_m; // decoded events plus the schedule pulse
      logic              dbg_wr;

      always_comb
      begin
         evt_m          = evt[i];
         evt_m.schedule = evt[i].schedule | sched[i];
      end

      assign dbg_wr = dbg_q.wr_en & (dbg_q.tid == `THR_ID_W'(i));

      thr_fsm u_fsm (.clk, .reset, .evt(evt_m), .com(com_q), .dbg_wr,
                     .dbg_state(dbg_q.state), .state(thr_state[i]));
   end

   thr_pick u_pick (.clk, .reset, .states(thr_state), .sched, .run_valid, .run_tid);

endmodule

//--- thr_switch_asserts.sv
/*
 * concurrent checks bound to the thread-switch top level
 * only one thread may run, states stay legal, the picker grants at most one
 * all checks are off while reset is high
 */
`include "thr_params.svh"

module thr_switch_asserts
(
   input logic                               clk,
   input logic                               reset,
   input thr_pkg::thr_state_e [`THR_NUM-1:0] thr_state,
   input logic [`THR_NUM-1:0]                sched,
   input logic                               run_valid
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [`THR_NUM-1:0] running;
   logic [`THR_NUM-1:0] legal;

   always_comb
   begin
      for (int t = 0; t < `THR_NUM; t++)
      begin
         running[t] = (thr_state[t] == thr_pkg::RUN) | (thr_state[t] == thr_pkg::SPEC_RUN);
         legal[t]   = thr_state[t] inside {thr_pkg::IDLE, thr_pkg::HALT, thr_pkg::RDY,
                      thr_pkg::RUN, thr_pkg::WAIT, thr_pkg::SPEC_RDY, thr_pkg::SPEC_RUN};
      end
   end

   one_runner: assert property (@(posedge clk) disable iff (reset) $countones(running) <= 1)
      else $error("more than one thread in RUN or SPEC_RUN");

   legal_state: assert property (@(posedge clk) disable iff (reset) &legal)
      else $error("thread state holds an unknown encoding");

   // single grant, and only with nobody running
   one_sched: assert property (@(posedge clk) disable iff (reset)
      $onehot0(sched) && (sched == '0 || !run_valid))
      else $error("picker raised sched wrongly");

endmodule

//--- thr_switch_tb.sv
/*
 * random testbench for the thread-switch unit
 * inputs change 1 ns after the rising edge, outputs are checked at that point too
 * the model keeps its own input register, transition table and picker
 * random debug writes load only non-running states so one thread runs at most
 * stops at the first mismatch
 */
`include "thr_params.svh"

module thr_switch_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int RESET_CYCLES = 8;
   localparam int STIM_CYCLES  = 1500;
   localparam int CYCLE_LIMIT  = STIM_CYCLES * 4 / 3; // room for reset and the directed start

   // one cycle of DUT inputs
   typedef struct packed
   {
      logic                 comp_valid;
      logic [`THR_ID_W-1:0] comp_tid;
      logic                 stall_valid;
      logic [`THR_ID_W-1:0] stall_tid;
      logic                 spec_valid;
      logic [`THR_ID_W-1:0] spec_tid;
      logic                 ldhit_valid;
      logic [`THR_ID_W-1:0] ldhit_tid;
      thr_pkg::thr_cmd_e    cmd;
      logic [`THR_ID_W-1:0] cmd_tid;
      thr_pkg::thr_common_t common;
      thr_pkg::thr_dbg_t    dbg;
   } in_t;

   logic                               clk   = 1'b0;
   logic                               reset = 1'b1;
   in_t                                drv   = '0; // applied to the DUT
   thr_pkg::thr_state_e [`THR_NUM-1:0] thr_state;
   logic                               run_valid;
   logic [`THR_ID_W-1:0]               run_tid;

   in_t                  reg_q = '0;   // model of the input register
   thr_pkg::thr_state_e  m_state [`THR_NUM];
   logic [`THR_ID_W-1:0] m_ptr = '0;   // model round-robin pointer
   logic [31:0]          lfsr  = 32'h71968fb7;
   int                   cycle_count = 0;

   thr_switch_top dut (.clk, .reset,
      .comp_valid(drv.comp_valid), .comp_tid(drv.comp_tid),
      .stall_valid(drv.stall_valid), .stall_tid(drv.stall_tid),
      .spec_valid(drv.spec_valid), .spec_tid(drv.spec_tid),
      .ldhit_valid(drv.ldhit_valid), .ldhit_tid(drv.ldhit_tid),
      .cmd(drv.cmd), .cmd_tid(drv.cmd_tid), .common(drv.common), .dbg(drv.dbg),
      .thr_state, .run_valid, .run_tid);

   bind thr_switch_top thr_switch_asserts u_asserts (.clk, .reset, .thr_state, .sched, .run_valid);

   always #5 clk = ~clk; // 10 ns period

   // run limit
   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT)
      begin
         $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("FAIL: see errors above");
         $fatal(1, "stopped by timeout");
      end
   end

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("FAIL: see errors above");
      $fatal(1, "check failed");
   endtask

   // right-shift Galois step, taps 32 30 26 25
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
   endfunction

   function automatic logic [31:0] take(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_step(lfsr); // one step per bit
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic in_t random_inputs();
      in_t        v;
      logic [2:0] c;
      logic [1:0] gate;
      v                   = '0;
      v.comp_valid        = (take(2) == 0);
      v.comp_tid          = `THR_ID_W'(take(`THR_ID_W));
      v.stall_valid       = (take(3) == 0); // rarer, else nothing ever runs
      v.stall_tid         = `THR_ID_W'(take(`THR_ID_W));
      v.spec_valid        = (take(2) == 0);
      v.spec_tid          = `THR_ID_W'(take(`THR_ID_W));
      v.ldhit_valid       = (take(2) == 0);
      v.ldhit_tid         = `THR_ID_W'(take(`THR_ID_W));
      gate                = 2'(take(2));
      c                   = 3'(take(3));
      if (gate == 2'd0 && c != 3'd7) // code 7 unused
         v.cmd = thr_pkg::thr_cmd_e'(c);
      v.cmd_tid           = `THR_ID_W'(take(`THR_ID_W));
      v.common.switch_out = (take(3) == 0);
      v.common.sw_cond    = (take(3) == 0);
      v.dbg.wr_en         = (take(4) == 0);
      v.dbg.tid           = `THR_ID_W'(take(`THR_ID_W));
      case (take(3) % 5)
         0:       v.dbg.state = thr_pkg::IDLE;
         1:       v.dbg.state = thr_pkg::HALT;
         2:       v.dbg.state = thr_pkg::RDY;
         3:       v.dbg.state = thr_pkg::WAIT;
         default: v.dbg.state = thr_pkg::SPEC_RDY;
      endcase
      return v;
   endfunction

   function automatic logic is_running(input thr_pkg::thr_state_e s);
      return (s == thr_pkg::RUN) || (s == thr_pkg::SPEC_RUN);
   endfunction

   function automatic logic is_ready(input thr_pkg::thr_state_e s);
      return (s == thr_pkg::RDY) || (s == thr_pkg::SPEC_RDY);
   endfunction

   // registered inputs as seen by thread t
   function automatic thr_pkg::thr_evt_t build_evt(input in_t r, input int t);
      thr_pkg::thr_evt_t e;
      logic              hit;
      e              = '0;
      hit            = (int'(r.cmd_tid) == t);
      e.completion   = r.comp_valid && (int'(r.comp_tid) == t);
      e.stall        = r.stall_valid && (int'(r.stall_tid) == t);
      e.spec_ld      = r.spec_valid && (int'(r.spec_tid) == t);
      e.ldhit        = r.ldhit_valid && (int'(r.ldhit_tid) == t);
      e.start_thread = hit && (r.cmd == thr_pkg::CMD_START);
      e.halt_thread  = hit && (r.cmd == thr_pkg::CMD_HALT);
      e.nuke_thread  = hit && (r.cmd == thr_pkg::CMD_NUKE);
      e.thaw_thread  = hit && (r.cmd == thr_pkg::CMD_THAW);
      e.rst_thread   = hit && (r.cmd == thr_pkg::CMD_RST);
      e.int_activate = hit && (r.cmd == thr_pkg::CMD_ACTIVATE);
      return e;
   endfunction

   // transition table, first match wins
   function automatic thr_pkg::thr_state_e next_state(input thr_pkg::thr_state_e s,
         input thr_pkg::thr_evt_t e, input thr_pkg::thr_common_t c);
      case (s)
         thr_pkg::IDLE:
            return (e.rst_thread || e.thaw_thread) ? thr_pkg::WAIT :
                   e.start_thread ? thr_pkg::RDY : s;
         thr_pkg::HALT:
            return e.nuke_thread ? thr_pkg::IDLE :
                   (e.rst_thread || e.thaw_thread) ? thr_pkg::WAIT :
                   (e.int_activate || e.start_thread) ? thr_pkg::RDY : s;
         thr_pkg::RDY:
            return e.stall ? thr_pkg::WAIT : e.schedule ? thr_pkg::RUN : s;
         thr_pkg::RUN:
            return (e.stall || c.sw_cond) ? thr_pkg::WAIT :
                   c.switch_out ? thr_pkg::RDY : s;
         thr_pkg::WAIT:
            return e.nuke_thread ? thr_pkg::IDLE : e.halt_thread ? thr_pkg::HALT :
                   e.stall ? thr_pkg::WAIT : e.spec_ld ? thr_pkg::SPEC_RDY :
                   e.completion ? thr_pkg::RDY : s;
         thr_pkg::SPEC_RDY:
            return e.stall ? thr_pkg::WAIT :
                   e.schedule ? (e.ldhit ? thr_pkg::RUN : thr_pkg::SPEC_RUN) :
                   e.ldhit ? thr_pkg::RDY : s;
         thr_pkg::SPEC_RUN:
            return (e.stall || c.sw_cond) ? thr_pkg::WAIT :
                   e.ldhit ? (c.switch_out ? thr_pkg::RDY : thr_pkg::RUN) :
                   c.switch_out ? thr_pkg::SPEC_RDY : s;
         default:
            return e.rst_thread ? thr_pkg::WAIT : e.nuke_thread ? thr_pkg::IDLE : s;
      endcase
   endfunction

   // one rising edge of the model
   task automatic model_step();
      logic [`THR_NUM-1:0]  sched;
      logic [`THR_ID_W-1:0] idx;
      logic [`THR_ID_W-1:0] ptr_n;
      logic                 busy;
      thr_pkg::thr_evt_t    e;
      busy  = 1'b0;
      sched = '0;
      ptr_n = m_ptr;
      for (int t = 0; t < `THR_NUM; t++)
         busy = busy | is_running(m_state[t]);
      for (int k = 0; k < `THR_NUM; k++)
      begin
         idx = m_ptr + `THR_ID_W'(k); // wraps, power-of-two count
         if (!busy && sched == '0 && is_ready(m_state[idx]))
         begin
            sched[idx] = 1'b1;
            ptr_n      = idx + 1'b1;
         end
      end
      for (int t = 0; t < `THR_NUM; t++)
      begin
         e          = build_evt(reg_q, t);
         e.schedule = sched[t];
         if (reg_q.dbg.wr_en && int'(reg_q.dbg.tid) == t)
            m_state[t] = reg_q.dbg.state; // debug wins
         else
            m_state[t] = next_state(m_state[t], e, reg_q.common);
      end
      m_ptr = ptr_n;
      reg_q = drv; // input register takes this cycle's drive
   endtask

   task automatic check_outputs();
      logic                 exp_valid;
      logic [`THR_ID_W-1:0] exp_tid;
      exp_valid = 1'b0;
      exp_tid   = '0;
      for (int t = `THR_NUM - 1; t >= 0; t--)
      begin
         if (is_running(m_state[t]))
         begin
            exp_valid = 1'b1;
            exp_tid   = `THR_ID_W'(t); // lowest index ends up here
         end
      end
      for (int t = 0; t < `THR_NUM; t++)
      begin
         assert (thr_state[t] == m_state[t])
         else stop_on_error($sformatf("** Error: thr_state[%0d] = 0x%h, expected 0x%h",
                                      t, thr_state[t], m_state[t]));
      end
      assert (run_valid == exp_valid)
      else stop_on_error($sformatf("** Error: run_valid = 0x%h, expected 0x%h",
                                   run_valid, exp_valid));
      assert (run_tid == exp_tid)
      else stop_on_error($sformatf("** Error: run_tid = 0x%h, expected 0x%h",
                                   run_tid, exp_tid));
   endtask

   task automatic run_cycle(input in_t v);
      @(posedge clk);
      #1;
      check_outputs(); // settled after the edge
      drv = v;
      model_step();
   endtask

   initial
   begin
      in_t v;
      for (int t = 0; t < `THR_NUM; t++)
         m_state[t] = thr_pkg::IDLE;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      check_outputs();
      reset = 1'b0;
      model_step();
      // start every thread in turn
      for (int t = 0; t < `THR_NUM; t++)
      begin
         v         = '0;
         v.cmd     = thr_pkg::CMD_START;
         v.cmd_tid = `THR_ID_W'(t);
         run_cycle(v);
      end
      // switch_out held, picker rotates through the ready threads
      v                   = '0;
      v.common.switch_out = 1'b1;
      repeat (3 * `THR_NUM) run_cycle(v);
      repeat (STIM_CYCLES) run_cycle(random_inputs());
      @(posedge clk);
      #1;
      check_outputs();
      $display("PASS: all tests");
      $finish;
   end

endmodule

//--- sim.f
+incdir+.
thr_pkg.sv
thr_evt_decode.sv
thr_fsm.sv
thr_pick.sv
thr_switch_top.sv
thr_switch_asserts.sv
thr_switch_tb.sv

//--- Makefile
# Verilator flow for the thread-switch unit
VERILATOR ?= verilator
TOP       ?= thr_switch_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
